// File: src.f
rtl/pe_pkg.sv
rtl/pe_operand_select.sv
rtl/pe_rf_capture.sv
rtl/pe_fu.sv
rtl/pe_delay_path.sv
rtl/stream_pe.sv
testbench/stream_pe_props.sv
testbench/stream_pe_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the streaming PE testbench with Verilator.
# Exit status is non-zero when the build fails or the run fails.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_stream_pe

verilator --binary --timing --assert -Wno-fatal \
  --top-module stream_pe_tb -f src.f -o "$BIN"
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

# Keep running past assertion errors so the testbench sees them all
./obj_dir/"$BIN" +verilator+error+limit+1000 > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "test failed" "$LOG"; then
  echo "Simulation FAILED"
  exit 1
fi

if [ "$run_status" -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

echo "Simulation PASSED"
exit 0

// File: testbench/stream_pe_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench of the streaming PE
// Runs phases of random control words with LFSR-driven neighbor data,
// back-pressure and done pulses. A cycle model predicts result, delay
// operand and capture strobe, compared every cycle at the falling edge.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module stream_pe_tb;
  import pe_pkg::*;

  localparam int RST_CYC     = 5;
  localparam int N_PHASE     = 64;
  localparam int PHASE_CYC   = 32;
  localparam int TEST_CYC    = RST_CYC + N_PHASE * PHASE_CYC + 4;
  localparam int TIMEOUT_CYC = 2 * TEST_CYC;

  logic                                clk_cg;
  logic                                rst_n;
  pe_cfg_t                             cfg;
  logic [DATA_W-1:0]                   const_v;
  logic [ACC_LEN_W-1:0]                acc_len;
  logic [RF_PER_W-1:0]                 rf_period;
  logic                                pea_ready;
  logic                                mage_done;
  operand_t  [N_NEIGH-1:0]             neigh_op;
  delay_op_t [N_NEIGH-1:0]             neigh_dly;
  logic [DATA_W-1:0]                   res;
  logic                                res_valid;
  delay_op_t                           dly;
  logic                                rf_de;
  logic [DATA_W-1:0]                   rf_d;

  // Model state and expected capture outputs
  logic [DATA_W-1:0]   m_res;
  logic                m_res_v;
  int                  m_beats;
  logic [RF_PER_W-1:0] m_rf_cnt;
  delay_op_t           m_dly;
  logic                exp_rf_de;
  logic [DATA_W-1:0]   exp_rf_d;
  logic [15:0]         lfsr_q;
  int                  cyc_cnt;
  int                  assert_fails;

  stream_pe i_stream_pe (
    .clk_cg      (clk_cg),
    .rst_n_i     (rst_n),
    .cfg_i       (cfg),
    .const_i     (const_v),
    .acc_len_i   (acc_len),
    .rf_period_i (rf_period),
    .pea_ready_i (pea_ready),
    .mage_done_i (mage_done),
    .neigh_op_i  (neigh_op),
    .neigh_dly_i (neigh_dly),
    .res_o       (res),
    .res_valid_o (res_valid),
    .dly_o       (dly),
    .rf_de_o     (rf_de),
    .rf_d_o      (rf_d)
  );

  initial begin
    clk_cg = 1'b0;
    forever #4 clk_cg = ~clk_cg;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string what);
    $display("test failed");
    $fatal(1, "%s", what);
  endtask

  // Fibonacci LFSR x^16+x^14+x^13+x^11+1, one step per bit
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      v      = {v[14:0], fb};
    end
    return v;
  endfunction

  task automatic check_res(input logic [DATA_W-1:0] got, input logic got_v,
                           input logic [DATA_W-1:0] exp, input logic exp_v);
    if (got !== exp || got_v !== exp_v) begin
      $display("** Error at %0t: res_o %h valid %b, expected %h valid %b",
               $time, got, got_v, exp, exp_v);
      abort_run("result mismatch");
    end
  endtask

  task automatic check_dly(input delay_op_t got, input delay_op_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: dly_o v%b f%b %h, expected v%b f%b %h", $time,
               got.valid, got.flag, got.data, exp.valid, exp.flag, exp.data);
      abort_run("delay operand mismatch");
    end
  endtask

  task automatic check_rf(input logic got_de, input logic [DATA_W-1:0] got_d,
                          input logic exp_de, input logic [DATA_W-1:0] exp_d);
    if (got_de !== exp_de || got_d !== exp_d) begin
      $display("** Error at %0t: rf_de_o %b rf_d_o %h, expected %b %h",
               $time, got_de, got_d, exp_de, exp_d);
      abort_run("capture mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Low half of the full-width result
  function automatic logic [DATA_W-1:0] fu_model(input fu_op_e op,
                                                 input logic [DATA_W-1:0] a,
                                                 input logic [DATA_W-1:0] b);
    logic [2*DATA_W-1:0] wide;
    wide = '0;
    case (op)
      OP_ADD, OP_ACC: wide = a + b;
      OP_SUB:         wide = a - b;
      OP_MUL:         wide = a * b;
      OP_AND:         wide = a & b;
      OP_OR:          wide = a | b;
      OP_MAX:         wide = ($signed(a) >= $signed(b)) ? a : b;
      default:        wide = '0;
    endcase
    return wide[DATA_W-1:0];
  endfunction

  function automatic operand_t src_operand(input pe_src_e s, input delay_op_t dsel);
    operand_t o;
    o = '0;
    case (s)
      SRC_N0, SRC_N1, SRC_N2, SRC_N3: o = neigh_op[s];
      SRC_SELF: begin
        o.valid = 1'b1;
        o.data  = m_res;
      end
      SRC_CONST: begin
        o.valid = 1'b1;
        o.data  = const_v;
      end
      SRC_DELAY: begin
        o.valid = dsel.valid;
        o.data  = dsel.data;
      end
      default: o = '0;
    endcase
    return o;
  endfunction

  // Expected capture outputs, then the state after the next rising edge
  task automatic model_eval();
    delay_op_t         dsel;
    pe_src_e           sa;
    operand_t          a;
    operand_t          b;
    logic              ovld;
    logic              red;
    logic              last;
    logic              fv;
    logic [DATA_W-1:0] fr;
    int                eff_len;
    dsel = neigh_dly[cfg.dly_in_sel];
    sa   = (m_beats != 0) ? SRC_SELF : cfg.src_a;
    a    = src_operand(sa, dsel);
    b    = src_operand(cfg.src_b, dsel);
    exp_rf_de = 1'b0;
    exp_rf_d  = '0;
    if (cfg.rf_en && pea_ready) begin
      if (cfg.rf_sel == RF_STREAM) begin
        exp_rf_de = neigh_op[0].valid && (m_rf_cnt == cfg.rf_val);
        exp_rf_d  = neigh_op[0].data;
      end else if (cfg.rf_sel == RF_OP_A) begin
        exp_rf_de = a.valid;
        exp_rf_d  = a.data;
      end else if (cfg.rf_sel == RF_OP_B) begin
        exp_rf_de = b.valid;
        exp_rf_d  = b.data;
      end
    end
    // Captured stream sample stands in for the constant
    if (exp_rf_de && cfg.rf_sel == RF_STREAM) begin
      if (sa == SRC_CONST) a.data = exp_rf_d;
      if (cfg.src_b == SRC_CONST) b.data = exp_rf_d;
    end
    ovld    = a.valid && b.valid;
    red     = cfg.op inside {OP_ACC, OP_MAX};
    eff_len = (acc_len == 0) ? 1 : int'(acc_len);
    last    = (m_beats + 1 >= eff_len);
    fr      = fu_model(cfg.op, a.data, b.data);
    fv      = ovld && (red ? last : (cfg.op != OP_NOP));
    if (mage_done) begin
      m_beats = 0;
    end else if (pea_ready && red && ovld) begin
      m_beats = last ? 0 : m_beats + 1;
    end
    if (mage_done || cfg.op == OP_NOP) begin
      m_res   = '0;
      m_res_v = 1'b0;
    end else if (pea_ready) begin
      m_res_v = fv;
      if (ovld) m_res = fr;
    end
    if (cfg.rf_en && neigh_op[0].valid && pea_ready) begin
      m_rf_cnt = (m_rf_cnt == rf_period) ? '0 : m_rf_cnt + 1'b1;
    end
    if (pea_ready && !mage_done) begin
      m_dly = dsel;
      case (cfg.dly_src)
        D_RES:  {m_dly.valid, m_dly.data} = {fv, fr};
        D_OP_A: {m_dly.valid, m_dly.data} = {a.valid, a.data};
        D_OP_B: {m_dly.valid, m_dly.data} = {b.valid, b.data};
        default: m_dly = dsel;
      endcase
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Sweeps ops, capture modes, delay sources and neighbor indices by phase
  task automatic set_config(input int p);
    cfg.src_a      = pe_src_e'(3'(rand_bits(3) % 7));
    cfg.src_b      = pe_src_e'(3'(rand_bits(3) % 7));
    cfg.op         = fu_op_e'(3'(p / 2));
    cfg.rf_en      = (rand_bits(2) != 0);
    cfg.rf_sel     = rf_sel_e'(2'(p % 3));
    cfg.rf_val     = RF_PER_W'(rand_bits(RF_PER_W));
    cfg.dly_in_sel = NEIGH_W'(p / 4);
    cfg.dly_src    = delay_src_e'(2'(p));
    const_v        = rand_bits(DATA_W);
    acc_len        = ACC_LEN_W'(rand_bits(3));
    rf_period      = RF_PER_W'(rand_bits(RF_PER_W));
  endtask

  task automatic drive_inputs();
    for (int i = 0; i < N_NEIGH; i++) begin
      neigh_op[i].valid  = (rand_bits(3) != 0);
      neigh_op[i].data   = rand_bits(DATA_W);
      neigh_dly[i].valid = (rand_bits(2) != 0);
      neigh_dly[i].flag  = rand_bits(1) != 0;
      neigh_dly[i].data  = rand_bits(DATA_W);
    end
    // Back-pressure about one cycle in eight, done rarely
    pea_ready = (rand_bits(3) != 0);
    mage_done = (rand_bits(5) == 0);
  endtask

  // Phase start has a done pulse so reductions line up with the new word
  task automatic step_cycle(input int p, input logic first);
    @(negedge clk_cg);
    check_res(res, res_valid, m_res, m_res_v);
    check_dly(dly, m_dly);
    if (first) set_config(p);
    drive_inputs();
    if (first) begin
      mage_done = 1'b1;
      pea_ready = 1'b1;
    end
    #1;
    model_eval();
    check_rf(rf_de, rf_d, exp_rf_de, exp_rf_d);
  endtask

  // Run limit
  always @(posedge clk_cg) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt >= TIMEOUT_CYC) begin
      $display("timeout: run did not end within %0d cycles", TIMEOUT_CYC);
      abort_run("timeout");
    end
  end

  initial begin
    lfsr_q    = 16'd37720;
    cyc_cnt   = 0;
    rst_n     = 1'b0;
    cfg       = '0;
    const_v   = '0;
    acc_len   = '0;
    rf_period = '0;
    pea_ready = 1'b0;
    mage_done = 1'b0;
    neigh_op  = '0;
    neigh_dly = '0;
    m_res     = '0;
    m_res_v   = 1'b0;
    m_beats   = 0;
    m_rf_cnt  = '0;
    m_dly     = '0;
    repeat (RST_CYC) @(negedge clk_cg);
    rst_n = 1'b1;
    // Everything zero out of reset
    #1;
    check_res(res, res_valid, '0, 1'b0);
    check_dly(dly, '0);
    check_rf(rf_de, rf_d, 1'b0, '0);
    for (int p = 0; p < N_PHASE; p++) begin
      for (int c = 0; c < PHASE_CYC; c++) begin
        step_cycle(p, c == 0);
      end
    end
    @(negedge clk_cg);
    check_res(res, res_valid, m_res, m_res_v);
    check_dly(dly, m_dly);
    assert_fails = i_stream_pe.i_pe_fu.i_fu_props.fail_cnt +
                   i_stream_pe.i_pe_delay_path.i_dly_props.fail_cnt;
    if (assert_fails == 0) begin
      $display("test passed");
      $finish;
    end else begin
      $display("%0d assertion failures", assert_fails);
      abort_run("assertion failures");
    end
  end

endmodule

// File: testbench/stream_pe_props.sv
////////////////////////////////////////////////////////////////////////////
// Concurrent checks on the PE result and delay registers
// Bound into the FU and the delay path. Counts its own failures.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module stream_pe_props #(
  parameter int W       = 1,
  parameter bit CHK_CLR = 1'b1
) (
  input logic         clk_cg,
  input logic         rst_n_i,
  input logic         pea_ready_i,
  input logic         clr_i,
  input logic [W-1:0] q_i,
  input logic         vld_i
);
  int unsigned fail_cnt = 0;

  // Register frozen under back-pressure unless cleared
  hold_a: assert property (@(posedge clk_cg) disable iff (!rst_n_i)
    !pea_ready_i && !clr_i |=> $stable(q_i))
    else begin
      fail_cnt++;
      $error("register changed while pea_ready_i low");
    end

  // NOP or done drops the valid
  if (CHK_CLR) begin : g_clear
    clear_a: assert property (@(posedge clk_cg) disable iff (!rst_n_i)
      clr_i |=> !vld_i)
      else begin
        fail_cnt++;
        $error("valid high after clear");
      end
  end

  // First edge out of reset
  reset_a: assert property (@(posedge clk_cg) $rose(rst_n_i) |-> !vld_i)
    else begin
      fail_cnt++;
      $error("valid high after reset");
    end

endmodule

bind pe_fu stream_pe_props #(.W(pe_pkg::DATA_W + 1)) i_fu_props (
  .clk_cg      (clk_cg),
  .rst_n_i     (rst_n_i),
  .pea_ready_i (pea_ready_i),
  .clr_i       (mage_done_i || op_i == pe_pkg::OP_NOP),
  .q_i         ({res_o, res_valid_o}),
  .vld_i       (res_valid_o)
);

// Delay register only freezes on done, never clears
bind pe_delay_path stream_pe_props #(
  .W       ($bits(pe_pkg::delay_op_t)),
  .CHK_CLR (1'b0)
) i_dly_props (
  .clk_cg      (clk_cg),
  .rst_n_i     (rst_n_i),
  .pea_ready_i (pea_ready_i),
  .clr_i       (1'b0),
  .q_i         (dly_o),
  .vld_i       (dly_o.valid)
);

// File: rtl/stream_pe.sv
////////////////////////////////////////////////////////////////////////////
// Streaming processing element of the reconfigurable array
// Top level of the PE. Connects operand selection, register-file capture,
// the functional unit and the delay-operand path. Clocked by clk_cg.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module stream_pe (
  input  logic                                    clk_cg,
  input  logic                                    rst_n_i,
  // Static control word and constants
  input  pe_pkg::pe_cfg_t                         cfg_i,
  input  logic [pe_pkg::DATA_W-1:0]               const_i,
  input  logic [pe_pkg::ACC_LEN_W-1:0]            acc_len_i,
  input  logic [pe_pkg::RF_PER_W-1:0]             rf_period_i,
  // Array control
  input  logic                                    pea_ready_i,
  input  logic                                    mage_done_i,
  // Neighbor operands, entry 0 is the stream input
  input  pe_pkg::operand_t  [pe_pkg::N_NEIGH-1:0] neigh_op_i,
  input  pe_pkg::delay_op_t [pe_pkg::N_NEIGH-1:0] neigh_dly_i,
  // Result and forwarded delay operand
  output logic [pe_pkg::DATA_W-1:0]               res_o,
  output logic                                    res_valid_o,
  output pe_pkg::delay_op_t                       dly_o,
  // Register-file capture
  output logic                                    rf_de_o,
  output logic [pe_pkg::DATA_W-1:0]               rf_d_o
);
  import pe_pkg::*;

  operand_t          op_a;
  operand_t          op_b;
  operand_t          raw_a;
  operand_t          raw_b;
  delay_op_t         dly_sel;
  logic              loopback;
  logic              stream_bypass;
  logic [DATA_W-1:0] fu_res;
  logic              fu_valid;

  ////////////////////////////////////////////////////////////////////////////
  // Operands and capture
  ////////////////////////////////////////////////////////////////////////////

  pe_operand_select i_pe_operand_select (
    .cfg_i           (cfg_i),
    .neigh_op_i      (neigh_op_i),
    .self_i          (res_o),
    .const_i         (const_i),
    .dly_sel_i       (dly_sel),
    .loopback_i      (loopback),
    .stream_bypass_i (stream_bypass),
    .rf_d_i          (rf_d_o),
    .op_a_o          (op_a),
    .op_b_o          (op_b),
    .raw_a_o         (raw_a),
    .raw_b_o         (raw_b)
  );

  pe_rf_capture i_pe_rf_capture (
    .clk_cg          (clk_cg),
    .rst_n_i         (rst_n_i),
    .cfg_i           (cfg_i),
    .stream_i        (neigh_op_i[0]),
    .raw_a_i         (raw_a),
    .raw_b_i         (raw_b),
    .rf_period_i     (rf_period_i),
    .pea_ready_i     (pea_ready_i),
    .rf_de_o         (rf_de_o),
    .rf_d_o          (rf_d_o),
    .stream_bypass_o (stream_bypass)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Compute and forward
  ////////////////////////////////////////////////////////////////////////////

  pe_fu i_pe_fu (
    .clk_cg      (clk_cg),
    .rst_n_i     (rst_n_i),
    .op_i        (cfg_i.op),
    .op_a_i      (op_a),
    .op_b_i      (op_b),
    .acc_len_i   (acc_len_i),
    .pea_ready_i (pea_ready_i),
    .mage_done_i (mage_done_i),
    .fu_res_o    (fu_res),
    .fu_valid_o  (fu_valid),
    .loopback_o  (loopback),
    .res_o       (res_o),
    .res_valid_o (res_valid_o)
  );

  pe_delay_path i_pe_delay_path (
    .clk_cg      (clk_cg),
    .rst_n_i     (rst_n_i),
    .cfg_i       (cfg_i),
    .neigh_dly_i (neigh_dly_i),
    .fu_res_i    (fu_res),
    .fu_valid_i  (fu_valid),
    .op_a_i      (op_a),
    .op_b_i      (op_b),
    .pea_ready_i (pea_ready_i),
    .mage_done_i (mage_done_i),
    .dly_sel_o   (dly_sel),
    .dly_o       (dly_o)
  );

endmodule

// File: rtl/pe_delay_path.sv
////////////////////////////////////////////////////////////////////////////
// Delay-operand forwarding of the streaming PE
// Selects one neighbor delay input, picks the forwarded source and holds
// it for one cycle. The flag always follows the selected neighbor.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pe_delay_path (
  input  logic                                    clk_cg,
  input  logic                                    rst_n_i,
  input  pe_pkg::pe_cfg_t                         cfg_i,
  input  pe_pkg::delay_op_t [pe_pkg::N_NEIGH-1:0] neigh_dly_i,
  input  logic [pe_pkg::DATA_W-1:0]               fu_res_i,
  input  logic                                    fu_valid_i,
  input  pe_pkg::operand_t                        op_a_i,
  input  pe_pkg::operand_t                        op_b_i,
  input  logic                                    pea_ready_i,
  input  logic                                    mage_done_i,
  output pe_pkg::delay_op_t                       dly_sel_o,
  output pe_pkg::delay_op_t                       dly_o
);
  import pe_pkg::*;

  delay_op_t dly_next;

  // Neighbor delay input, also the SRC_DELAY operand
  assign dly_sel_o = neigh_dly_i[cfg_i.dly_in_sel];

  // Forwarded source
  always_comb begin
    dly_next = dly_sel_o;
    case (cfg_i.dly_src)
      D_RES: begin
        dly_next.valid = fu_valid_i;
        dly_next.data  = fu_res_i;
      end
      D_OP_A: begin
        dly_next.valid = op_a_i.valid;
        dly_next.data  = op_a_i.data;
      end
      D_OP_B: begin
        dly_next.valid = op_b_i.valid;
        dly_next.data  = op_b_i.data;
      end
      default: dly_next = dly_sel_o;
    endcase
  end

  // One-cycle delay register, frozen by back-pressure and done
  always_ff @(posedge clk_cg, negedge rst_n_i) begin
    if (!rst_n_i) begin
      dly_o <= '0;
    end else if (pea_ready_i && !mage_done_i) begin
      dly_o <= dly_next;
    end
  end

endmodule

// File: rtl/pe_fu.sv
////////////////////////////////////////////////////////////////////////////
// Functional unit of the streaming PE
// Single-beat ALU operations plus ACC and MAX reductions over acc_len_i
// beats. Owns the result and valid registers, cleared by NOP or done.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pe_fu (
  input  logic                         clk_cg,
  input  logic                         rst_n_i,
  input  pe_pkg::fu_op_e               op_i,
  input  pe_pkg::operand_t             op_a_i,
  input  pe_pkg::operand_t             op_b_i,
  input  logic [pe_pkg::ACC_LEN_W-1:0] acc_len_i,
  input  logic                         pea_ready_i,
  input  logic                         mage_done_i,
  output logic [pe_pkg::DATA_W-1:0]    fu_res_o,
  output logic                         fu_valid_o,
  output logic                         loopback_o,
  output logic [pe_pkg::DATA_W-1:0]    res_o,
  output logic                         res_valid_o
);
  import pe_pkg::*;

  logic                 ops_valid;
  logic                 is_red;
  logic                 red_last;
  logic [ACC_LEN_W-1:0] acc_cnt;
  logic [ACC_LEN_W-1:0] acc_last;

  assign ops_valid = op_a_i.valid && op_b_i.valid;
  assign is_red    = (op_i == OP_ACC) || (op_i == OP_MAX);

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  // Results wrap to DATA_W, MUL keeps the low half
  always_comb begin
    case (op_i)
      OP_ADD: fu_res_o = op_a_i.data + op_b_i.data;
      OP_SUB: fu_res_o = op_a_i.data - op_b_i.data;
      OP_MUL: fu_res_o = op_a_i.data * op_b_i.data;
      OP_AND: fu_res_o = op_a_i.data & op_b_i.data;
      OP_OR:  fu_res_o = op_a_i.data | op_b_i.data;
      OP_ACC: fu_res_o = op_a_i.data + op_b_i.data;
      // Signed maximum
      OP_MAX: begin
        fu_res_o = ($signed(op_a_i.data) > $signed(op_b_i.data)) ?
                   op_a_i.data : op_b_i.data;
      end
      default: fu_res_o = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reduction control
  ////////////////////////////////////////////////////////////////////////////

  // Zero length behaves as one beat
  assign acc_last = (acc_len_i == '0) ? '0 : acc_len_i - 1'b1;
  assign red_last = (acc_cnt == acc_last);

  always_ff @(posedge clk_cg, negedge rst_n_i) begin
    if (!rst_n_i) begin
      acc_cnt <= '0;
    end else if (mage_done_i) begin
      acc_cnt <= '0;
    end else if (pea_ready_i && is_red && ops_valid) begin
      if (red_last) begin
        acc_cnt <= '0;
      end else begin
        acc_cnt <= acc_cnt + 1'b1;
      end
    end
  end

  // Past the first beat A comes from the running result
  assign loopback_o = (acc_cnt != '0);

  // Reductions are valid only on their closing beat
  assign fu_valid_o = ops_valid && (is_red ? red_last : (op_i != OP_NOP));

  ////////////////////////////////////////////////////////////////////////////
  // Result register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_cg, negedge rst_n_i) begin
    if (!rst_n_i) begin
      res_o       <= '0;
      res_valid_o <= 1'b0;
    end else if (mage_done_i || op_i == OP_NOP) begin
      res_o       <= '0;
      res_valid_o <= 1'b0;
    end else if (pea_ready_i) begin
      res_valid_o <= fu_valid_o;
      // Reductions update on every beat
      if (ops_valid) begin
        res_o <= fu_res_o;
      end
    end
  end

endmodule

// File: rtl/pe_rf_capture.sv
////////////////////////////////////////////////////////////////////////////
// One-entry register-file capture of the streaming PE
// Counts stream beats and strobes the capture of the stream input or of
// one raw FU operand, as rf_sel of the control word asks.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pe_rf_capture (
  input  logic                        clk_cg,
  input  logic                        rst_n_i,
  input  pe_pkg::pe_cfg_t             cfg_i,
  input  pe_pkg::operand_t            stream_i,
  input  pe_pkg::operand_t            raw_a_i,
  input  pe_pkg::operand_t            raw_b_i,
  input  logic [pe_pkg::RF_PER_W-1:0] rf_period_i,
  input  logic                        pea_ready_i,
  output logic                        rf_de_o,
  output logic [pe_pkg::DATA_W-1:0]   rf_d_o,
  output logic                        stream_bypass_o
);
  import pe_pkg::*;

  logic [RF_PER_W-1:0] rf_cnt;
  logic                cnt_step;

  // Sampling counter, advances on each accepted stream beat
  assign cnt_step = cfg_i.rf_en && stream_i.valid && pea_ready_i;

  always_ff @(posedge clk_cg, negedge rst_n_i) begin
    if (!rst_n_i) begin
      rf_cnt <= '0;
    end else if (cnt_step) begin
      // Wrap once the period is reached
      if (rf_cnt == rf_period_i) begin
        rf_cnt <= '0;
      end else begin
        rf_cnt <= rf_cnt + 1'b1;
      end
    end
  end

  // Capture strobe and data
  always_comb begin
    rf_de_o = 1'b0;
    rf_d_o  = '0;
    if (cfg_i.rf_en && pea_ready_i) begin
      case (cfg_i.rf_sel)
        RF_STREAM: begin
          rf_de_o = stream_i.valid && (rf_cnt == cfg_i.rf_val);
          rf_d_o  = stream_i.data;
        end
        RF_OP_A: begin
          rf_de_o = raw_a_i.valid;
          rf_d_o  = raw_a_i.data;
        end
        RF_OP_B: begin
          rf_de_o = raw_b_i.valid;
          rf_d_o  = raw_b_i.data;
        end
        default: begin
          rf_de_o = 1'b0;
          rf_d_o  = '0;
        end
      endcase
    end
  end

  // Stream capture also feeds the constant operand
  assign stream_bypass_o = rf_de_o && (cfg_i.rf_sel == RF_STREAM);

endmodule

// File: rtl/pe_operand_select.sv
////////////////////////////////////////////////////////////////////////////
// Operand selection of the streaming PE
// Builds the operand table, forces source A onto the PE result during a
// reduction and drives both FU operands, raw and after the stream bypass.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pe_operand_select (
  input  pe_pkg::pe_cfg_t                        cfg_i,
  input  pe_pkg::operand_t [pe_pkg::N_NEIGH-1:0] neigh_op_i,
  input  logic [pe_pkg::DATA_W-1:0]              self_i,
  input  logic [pe_pkg::DATA_W-1:0]              const_i,
  input  pe_pkg::delay_op_t                      dly_sel_i,
  input  logic                                   loopback_i,
  input  logic                                   stream_bypass_i,
  input  logic [pe_pkg::DATA_W-1:0]              rf_d_i,
  output pe_pkg::operand_t                       op_a_o,
  output pe_pkg::operand_t                       op_b_o,
  output pe_pkg::operand_t                       raw_a_o,
  output pe_pkg::operand_t                       raw_b_o
);
  import pe_pkg::*;

  operand_t [N_SRC-1:0] op_tab;
  pe_src_e              sel_a;
  pe_src_e              sel_b;

  // Operand table
  always_comb begin
    op_tab = '0;
    for (int i = 0; i < N_NEIGH; i++) begin
      op_tab[i] = neigh_op_i[i];
    end
    // Own result, constant and delay operand
    op_tab[SRC_SELF]  = '{valid: 1'b1, data: self_i};
    op_tab[SRC_CONST] = '{valid: 1'b1, data: const_i};
    op_tab[SRC_DELAY] = '{valid: dly_sel_i.valid, data: dly_sel_i.data};
  end

  // Reduction feeds the running result back on A
  assign sel_a = loopback_i ? SRC_SELF : cfg_i.src_a;
  assign sel_b = cfg_i.src_b;

  assign raw_a_o = op_tab[sel_a];
  assign raw_b_o = op_tab[sel_b];

  // Captured stream data replaces the constant in the capture cycle
  always_comb begin
    op_a_o = raw_a_o;
    op_b_o = raw_b_o;
    if (stream_bypass_i && sel_a == SRC_CONST) begin
      op_a_o.data = rf_d_i;
    end
    if (stream_bypass_i && sel_b == SRC_CONST) begin
      op_b_o.data = rf_d_i;
    end
  end

endmodule

// File: rtl/pe_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared widths, encodings and bundles of the streaming PE
// Imported by every RTL block of the PE and by the testbench model.
// The control word is static for a whole run of the array.
////////////////////////////////////////////////////////////////////////////

package pe_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Geometry
  ////////////////////////////////////////////////////////////////////////////

  // Datapath width
  localparam int DATA_W    = 16;
  // Neighbor operand and neighbor delay inputs
  localparam int N_NEIGH   = 4;
  localparam int NEIGH_W   = $clog2(N_NEIGH);
  // Reduction length and capture period widths
  localparam int ACC_LEN_W = 8;
  localparam int RF_PER_W  = 2;
  // Operand table depth, one slot spare
  localparam int N_SRC     = 8;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  // Operand sources, neighbor 0 is the stream input
  typedef enum logic [2:0] {
    SRC_N0    = 3'd0,
    SRC_N1    = 3'd1,
    SRC_N2    = 3'd2,
    SRC_N3    = 3'd3,
    SRC_SELF  = 3'd4,
    SRC_CONST = 3'd5,
    SRC_DELAY = 3'd6
  } pe_src_e;

  // FU operations
  typedef enum logic [2:0] {
    OP_NOP = 3'd0,
    OP_ADD = 3'd1,
    OP_SUB = 3'd2,
    OP_MUL = 3'd3,
    OP_AND = 3'd4,
    OP_OR  = 3'd5,
    OP_ACC = 3'd6,
    OP_MAX = 3'd7
  } fu_op_e;

  // Register-file capture source
  typedef enum logic [1:0] {
    RF_STREAM = 2'd0,
    RF_OP_A   = 2'd1,
    RF_OP_B   = 2'd2
  } rf_sel_e;

  // Forwarded delay-operand source
  typedef enum logic [1:0] {
    D_RES  = 2'd0,
    D_OP_A = 2'd1,
    D_OP_B = 2'd2,
    D_PASS = 2'd3
  } delay_src_e;

  ////////////////////////////////////////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////////////////////////////////////////

  // Operand with its valid, 17 bits
  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] data;
  } operand_t;

  // Delay operand, the flag rides along with the data
  typedef struct packed {
    logic              valid;
    logic              flag;
    logic [DATA_W-1:0] data;
  } delay_op_t;

  // Control word, 18 bits
  typedef struct packed {
    pe_src_e              src_a;
    pe_src_e              src_b;
    fu_op_e               op;
    logic                 rf_en;
    rf_sel_e              rf_sel;
    logic [RF_PER_W-1:0]  rf_val;
    logic [NEIGH_W-1:0]   dly_in_sel;
    delay_src_e           dly_src;
  } pe_cfg_t;

endpackage
